//--- design/vga_pkg.sv
package vga_pkg;

  // dot and row counter value
  typedef logic [9:0] count_t;
  // sram word address, one word per pixel
  typedef logic [18:0] vaddr_t;
  // cpu side address bus
  typedef logic [19:0] caddr_t;
  // rgb565 pixel, also the sram data width
  typedef logic [15:0] pixel_t;

  // 640x480 at 60 hz, 800 dots by 525 rows
  localparam int H_TOTAL = 800;
  localparam int V_TOTAL = 525;

  // hsync low on these dots, inclusive
  localparam int H_SYNC_BEG = 16;
  localparam int H_SYNC_END = 111;
  // vsync low on these rows, inclusive
  localparam int V_SYNC_BEG = 10;
  localparam int V_SYNC_END = 11;

  // active area runs from here to the last dot and row
  localparam int H_ACT_BEG = 160;
  localparam int V_ACT_BEG = 45;

  // frame buffer size in words
  localparam int VRAM_WORDS = 307200;
  // cpu window start, window is VRAM_BASE .. VRAM_BASE + VRAM_WORDS - 1
  localparam caddr_t VRAM_BASE = 20'h80000;

  // sram owner
  typedef enum logic [1:0] {
    SCAN,
    CPU_ACC,
    CPU_DONE
  } ctrl_state_t;

endpackage

//--- design/vga_timing.sv
`timescale 1ns/10ps

module vga_timing (
  input  logic i_clk_int,
  input  logic i_rst,
  output logic o_hs,
  output logic o_vs,
  output logic o_de,
  output logic o_active_now,
  output logic o_frame_start
);

  // raw counters
  vga_pkg::count_t dot;
  vga_pkg::count_t row;

  logic line_end;
  logic frame_end;
  logic h_act;
  logic v_act;
  logic hs_next;
  logic vs_next;

  // last dot of a line, last row of a frame
  assign line_end  = (dot == vga_pkg::count_t'(vga_pkg::H_TOTAL - 1));
  assign frame_end = (row == vga_pkg::count_t'(vga_pkg::V_TOTAL - 1));

  // dot and row counters
  always_ff @(posedge i_clk_int) begin
    if (i_rst) begin
      dot <= '0;
      row <= '0;
    end else if (line_end) begin
      dot <= '0;
      // row steps once per line
      if (frame_end) begin
        row <= '0;
      end else begin
        row <= row + 1'b1;
      end
    end else begin
      dot <= dot + 1'b1;
    end
  end

  // active area, both counters past their blanking
  assign h_act = (dot >= vga_pkg::H_ACT_BEG);
  assign v_act = (row >= vga_pkg::V_ACT_BEG);
  assign o_active_now = h_act && v_act;

  // first dot of the frame, restarts the scan pointer
  assign o_frame_start = (dot == '0) && (row == '0);

  // sync pulses, active low
  assign hs_next = !((dot >= vga_pkg::H_SYNC_BEG) && (dot <= vga_pkg::H_SYNC_END));
  assign vs_next = !((row >= vga_pkg::V_SYNC_BEG) && (row <= vga_pkg::V_SYNC_END));

  // registered outputs, one cycle behind the counters
  always_ff @(posedge i_clk_int) begin
    if (i_rst) begin
      o_hs <= 1'b1;
      o_vs <= 1'b1;
      o_de <= 1'b0;
    end else begin
      o_hs <= hs_next;
      o_vs <= vs_next;
      // lines up with the pixel register in scan_addr
      o_de <= o_active_now;
    end
  end

endmodule

//--- design/scan_addr.sv
`timescale 1ns/10ps

module scan_addr (
  input  logic            i_clk_int,
  input  logic            i_rst,
  input  logic            i_active_now,
  input  logic            i_frame_start,
  input  vga_pkg::pixel_t i_mem_rdata,
  output vga_pkg::vaddr_t o_scan_addr,
  output vga_pkg::pixel_t o_pixel
);

  logic ptr_last;

  // last word of the frame buffer
  assign ptr_last = (o_scan_addr == vga_pkg::vaddr_t'(vga_pkg::VRAM_WORDS - 1));

  // frame buffer pointer
  always_ff @(posedge i_clk_int) begin
    if (i_rst) begin
      o_scan_addr <= '0;
    end else if (i_frame_start) begin
      // realign every frame
      o_scan_addr <= '0;
    end else if (i_active_now) begin
      if (ptr_last) begin
        o_scan_addr <= '0;
      end else begin
        o_scan_addr <= o_scan_addr + 1'b1;
      end
    end
  end

  // pixel register
  // loads on the same edge as o_de rises, holds through blanking
  always_ff @(posedge i_clk_int) begin
    if (i_active_now) begin
      o_pixel <= i_mem_rdata;
    end
  end

endmodule

//--- design/cpu_mem_port.sv
`timescale 1ns/10ps

module cpu_mem_port (
  input  logic            i_clk_int,
  input  logic            i_rst,
  input  vga_pkg::caddr_t i_addr,
  input  vga_pkg::pixel_t i_data,
  input  logic            i_read_q,
  input  logic            i_write_q,
  input  logic            i_grant,
  input  vga_pkg::pixel_t i_mem_rdata,
  output logic            o_req_pending,
  output logic            o_is_write,
  output vga_pkg::vaddr_t o_vaddr,
  output vga_pkg::pixel_t o_wdata,
  output vga_pkg::pixel_t o_data,
  output vga_pkg::caddr_t o_addr,
  output logic            o_read_dn,
  output logic            o_write_dn
);

  logic req_any;
  logic in_win;
  logic accept;
  // out of window request, finishes without memory
  logic oow_q;
  // waits for the request to drop after done
  logic rearm;

  assign req_any = i_read_q || i_write_q;
  assign in_win  = (i_addr >= vga_pkg::VRAM_BASE) &&
                   (i_addr < vga_pkg::VRAM_BASE + vga_pkg::VRAM_WORDS);
  // new request only when idle and re-armed
  assign accept  = req_any && !o_req_pending && !oow_q && !rearm;

  // control flags
  always_ff @(posedge i_clk_int) begin
    if (i_rst) begin
      o_req_pending <= 1'b0;
      oow_q         <= 1'b0;
      rearm         <= 1'b0;
      o_read_dn     <= 1'b0;
      o_write_dn    <= 1'b0;
    end else begin
      // done pulses are one cycle wide
      o_read_dn  <= 1'b0;
      o_write_dn <= 1'b0;
      if (accept) begin
        o_req_pending <= in_win;
        oow_q         <= !in_win;
      end else if (i_grant || oow_q) begin
        o_req_pending <= 1'b0;
        oow_q         <= 1'b0;
        o_read_dn     <= !o_is_write;
        o_write_dn    <= o_is_write;
      end
      // set with done, cleared once the cpu lets go
      if (i_grant || oow_q) begin
        rearm <= 1'b1;
      end else if (!req_any) begin
        rearm <= 1'b0;
      end
    end
  end

  // request payload, write wins over read
  always_ff @(posedge i_clk_int) begin
    if (accept) begin
      o_is_write <= i_write_q;
      o_addr     <= i_addr;
      o_vaddr    <= vga_pkg::vaddr_t'(i_addr - vga_pkg::VRAM_BASE);
      o_wdata    <= i_data;
    end
  end

  // read data, captured on the granted cycle
  always_ff @(posedge i_clk_int) begin
    if (i_grant && !o_is_write) begin
      o_data <= i_mem_rdata;
    end else if (oow_q) begin
      // nothing behind an out of window address
      o_data <= '0;
    end
  end

endmodule

//--- design/vram_ctrl.sv
`timescale 1ns/10ps

module vram_ctrl (
  input  logic            i_clk_int,
  input  logic            i_rst,
  input  logic            i_active_now,
  input  logic            i_rw_halt,
  input  logic            i_req_pending,
  input  logic            i_is_write,
  input  vga_pkg::vaddr_t i_scan_addr,
  input  vga_pkg::vaddr_t i_cpu_vaddr,
  output logic            o_grant,
  output vga_pkg::vaddr_t o_mem_addr,
  output logic            o_mem_oe_n,
  output logic            o_mem_we_n
);

  vga_pkg::ctrl_state_t state;
  vga_pkg::ctrl_state_t state_nxt;

  // cpu owns the sram this cycle
  logic cpu_slot;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      vga_pkg::SCAN: begin
        // cpu fits only into blanking and only when not halted
        if (i_req_pending && !i_active_now && !i_rw_halt) begin
          state_nxt = vga_pkg::CPU_ACC;
        end
      end
      vga_pkg::CPU_ACC: begin
        // active area began, scanout wins and the request retries
        if (i_active_now) begin
          state_nxt = vga_pkg::SCAN;
        end else begin
          state_nxt = vga_pkg::CPU_DONE;
        end
      end
      vga_pkg::CPU_DONE: begin
        state_nxt = vga_pkg::SCAN;
      end
      default: begin
        state_nxt = vga_pkg::SCAN;
      end
    endcase
  end

  // state register
  always_ff @(posedge i_clk_int) begin
    if (i_rst) begin
      state <= vga_pkg::SCAN;
    end else begin
      state <= state_nxt;
    end
  end

  // single cycle access slot
  assign cpu_slot = (state == vga_pkg::CPU_ACC) && !i_active_now;
  assign o_grant  = cpu_slot;

  // address select, scan pointer unless the cpu holds the slot
  assign o_mem_addr = cpu_slot ? i_cpu_vaddr : i_scan_addr;

  // strobes, output enable stays low for scan and cpu reads
  assign o_mem_we_n = !(cpu_slot && i_is_write);
  assign o_mem_oe_n = cpu_slot && i_is_write;

endmodule

//--- design/vga_vram_top.sv
`timescale 1ns/10ps

module vga_vram_top (
  input  logic            i_clk_int,
  input  logic            i_rst,
  input  vga_pkg::caddr_t i_addr,
  input  vga_pkg::pixel_t i_data,
  input  logic            i_read_q,
  input  logic            i_write_q,
  input  logic            i_rw_halt,
  output vga_pkg::caddr_t o_addr,
  output vga_pkg::pixel_t o_data,
  output logic            o_read_dn,
  output logic            o_write_dn,
  output logic            o_hs,
  output logic            o_vs,
  output logic            o_de,
  output vga_pkg::pixel_t o_pixel,
  output vga_pkg::vaddr_t o_mem_addr,
  output vga_pkg::pixel_t o_mem_wdata,
  output logic            o_mem_oe_n,
  output logic            o_mem_we_n,
  input  vga_pkg::pixel_t i_mem_rdata
);

  // timing to scan and control
  logic            active_now;
  logic            frame_start;
  // scan pointer
  vga_pkg::vaddr_t scan_addr_q;
  // cpu request towards the controller
  logic            req_pending;
  logic            cpu_is_write;
  vga_pkg::vaddr_t cpu_vaddr;
  logic            grant;

  vga_timing u_timing (
    .i_clk_int     (i_clk_int),
    .i_rst         (i_rst),
    .o_hs          (o_hs),
    .o_vs          (o_vs),
    .o_de          (o_de),
    .o_active_now  (active_now),
    .o_frame_start (frame_start)
  );

  scan_addr u_scan (
    .i_clk_int     (i_clk_int),
    .i_rst         (i_rst),
    .i_active_now  (active_now),
    .i_frame_start (frame_start),
    .i_mem_rdata   (i_mem_rdata),
    .o_scan_addr   (scan_addr_q),
    .o_pixel       (o_pixel)
  );

  // write data goes straight out to the sram
  cpu_mem_port u_cpu (
    .i_clk_int     (i_clk_int),
    .i_rst         (i_rst),
    .i_addr        (i_addr),
    .i_data        (i_data),
    .i_read_q      (i_read_q),
    .i_write_q     (i_write_q),
    .i_grant       (grant),
    .i_mem_rdata   (i_mem_rdata),
    .o_req_pending (req_pending),
    .o_is_write    (cpu_is_write),
    .o_vaddr       (cpu_vaddr),
    .o_wdata       (o_mem_wdata),
    .o_data        (o_data),
    .o_addr        (o_addr),
    .o_read_dn     (o_read_dn),
    .o_write_dn    (o_write_dn)
  );

  vram_ctrl u_ctrl (
    .i_clk_int     (i_clk_int),
    .i_rst         (i_rst),
    .i_active_now  (active_now),
    .i_rw_halt     (i_rw_halt),
    .i_req_pending (req_pending),
    .i_is_write    (cpu_is_write),
    .i_scan_addr   (scan_addr_q),
    .i_cpu_vaddr   (cpu_vaddr),
    .o_grant       (grant),
    .o_mem_addr    (o_mem_addr),
    .o_mem_oe_n    (o_mem_oe_n),
    .o_mem_we_n    (o_mem_we_n)
  );

endmodule

//--- testbench/vga_vram_chk.sv
`timescale 1ns/10ps

module vga_vram_chk (
  input logic                 i_clk_int,
  input logic                 i_rst,
  input logic                 i_mem_we_n,
  input vga_pkg::ctrl_state_t i_state,
  input logic                 i_active_now,
  input logic                 i_grant,
  input logic                 i_read_dn,
  input logic                 i_write_dn
);

  // write strobe only in a slot entered from scanout during blanking
  assert property (@(posedge i_clk_int) disable iff (i_rst)
    !i_mem_we_n |-> ($past(i_state) == vga_pkg::SCAN) && !$past(i_active_now))
    else $error("sram write strobe outside the cpu access slot");

  // grant is a single cycle pulse
  assert property (@(posedge i_clk_int) disable iff (i_rst)
    i_grant |=> !i_grant)
    else $error("grant held for more than one cycle");

  // CPU_DONE always hands the sram back to scanout
  assert property (@(posedge i_clk_int) disable iff (i_rst)
    (i_state == vga_pkg::CPU_DONE) |=> (i_state == vga_pkg::SCAN))
    else $error("controller left CPU_DONE for a state other than SCAN");

  // one kind of completion at a time
  assert property (@(posedge i_clk_int) disable iff (i_rst)
    !(i_read_dn && i_write_dn))
    else $error("read done and write done high together");

endmodule

// controller side, no done pulses here
bind vram_ctrl vga_vram_chk u_chk_ctrl (
  .i_clk_int    (i_clk_int),
  .i_rst        (i_rst),
  .i_mem_we_n   (o_mem_we_n),
  .i_state      (state),
  .i_active_now (i_active_now),
  .i_grant      (o_grant),
  .i_read_dn    (1'b0),
  .i_write_dn   (1'b0)
);

// cpu port side, strobes tied inactive
bind cpu_mem_port vga_vram_chk u_chk_cpu (
  .i_clk_int    (i_clk_int),
  .i_rst        (i_rst),
  .i_mem_we_n   (1'b1),
  .i_state      (vga_pkg::SCAN),
  .i_active_now (1'b0),
  .i_grant      (i_grant),
  .i_read_dn    (o_read_dn),
  .i_write_dn   (o_write_dn)
);

//--- testbench/vga_vram_tb.sv
`timescale 1ns/10ps

module vga_vram_tb;

  localparam int FRAME_CYCLES = 420000;
  localparam int MAX_OPS      = 32;
  localparam int OP_COLS      = 5;
  localparam int SRAM_WORDS   = 524288;

  logic            clk_int;
  logic            rst;
  vga_pkg::caddr_t addr;
  vga_pkg::pixel_t wdata;
  logic            read_q;
  logic            write_q;
  logic            rw_halt;
  vga_pkg::caddr_t rd_addr;
  vga_pkg::pixel_t rd_data;
  logic            read_dn;
  logic            write_dn;
  logic            hs;
  logic            vs;
  logic            de;
  vga_pkg::pixel_t pixel;
  vga_pkg::vaddr_t mem_addr;
  vga_pkg::pixel_t mem_wdata;
  logic            mem_oe_n;
  logic            mem_we_n;
  vga_pkg::pixel_t mem_rdata;

  // sram model and the expected image of it
  logic [15:0] sram    [0:SRAM_WORDS-1];
  logic [15:0] exp_mem [0:SRAM_WORDS-1];
  // five columns per cpu operation
  logic [19:0] tdata   [0:MAX_OPS*OP_COLS-1];

  int errors;
  int checks;
  int cyc;
  int n_ops;
  int timeout_limit;
  int test_err [1:6];
  int test_chk [1:6];
  bit prev_de;

  vga_vram_top u_dut (
    .i_clk_int   (clk_int),
    .i_rst       (rst),
    .i_addr      (addr),
    .i_data      (wdata),
    .i_read_q    (read_q),
    .i_write_q   (write_q),
    .i_rw_halt   (rw_halt),
    .o_addr      (rd_addr),
    .o_data      (rd_data),
    .o_read_dn   (read_dn),
    .o_write_dn  (write_dn),
    .o_hs        (hs),
    .o_vs        (vs),
    .o_de        (de),
    .o_pixel     (pixel),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_mem_oe_n  (mem_oe_n),
    .o_mem_we_n  (mem_we_n),
    .i_mem_rdata (mem_rdata)
  );

  // 40 ns period
  always #20 clk_int = ~clk_int;

  // run limit
  always @(posedge clk_int) begin
    cyc = cyc + 1;
    if (cyc > timeout_limit) begin
      $display("timeout after %0d cycles, the run did not complete", cyc);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // asynchronous read while output enable is low, write on the edge
  assign mem_rdata = !mem_oe_n ? sram[mem_addr] : 'x;
  always @(posedge clk_int) begin
    if (!mem_we_n) begin
      sram[mem_addr] <= mem_wdata;
    end
  end

  // output enable must be off while the sram is written
  always @(negedge clk_int) begin
    if (!mem_we_n) begin
      check_true(4, mem_oe_n, "sram output enable low during a write");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input int test, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    checks++;
    test_chk[test]++;
    assert (got === exp) else begin
      $display("error t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errors++;
      test_err[test]++;
    end
  endtask

  task automatic check_true(input int test, input bit cond, input string what);
    checks++;
    test_chk[test]++;
    assert (cond) else begin
      $display("failure t=%0t %s", $time, what);
      errors++;
      test_err[test]++;
    end
  endtask

  task automatic print_test(input int test, input string name);
    $display("test %0d %s: %0d checks, %0d errors", test, name, test_chk[test], test_err[test]);
  endtask

  // whole sram against the expected image
  task automatic compare_memory();
    int diffs = 0;
    for (int j = 0; j < SRAM_WORDS; j++) begin
      if (sram[j] !== exp_mem[j]) begin
        diffs++;
      end
    end
    check_value(5, "changed sram words", diffs, 0);
  endtask

  // one frame of sync, enable and pixel checks, sampled mid cycle
  task automatic run_frame_checks();
    int hs_run = 0;
    int vs_run = 0;
    int de_run = 0;
    int hs_pulses = 0;
    int vs_pulses = 0;
    int de_lines = 0;
    int de_total = 0;
    int n = 0;
    bit hs_p = 1'b1;
    bit vs_p = 1'b1;
    bit de_p = 1'b0;
    for (int k = 0; k < FRAME_CYCLES; k++) begin
      @(negedge clk_int);
      if (!hs) begin
        hs_run++;
      end else if (!hs_p) begin
        check_value(1, "o_hs low run", hs_run, 96);
        hs_pulses++;
        hs_run = 0;
      end
      if (!vs) begin
        vs_run++;
      end else if (!vs_p) begin
        check_value(1, "o_vs low run", vs_run, 1600);
        vs_pulses++;
        vs_run = 0;
      end
      // n-th enabled cycle shows word n
      if (de) begin
        de_run++;
        de_total++;
        check_value(3, "o_pixel", pixel, exp_mem[n]);
        n++;
      end else if (de_p) begin
        check_value(2, "o_de line run", de_run, 640);
        de_lines++;
        de_run = 0;
      end
      hs_p = hs;
      vs_p = vs;
      de_p = de;
    end
    // last line ends at the frame boundary
    if (de_p) begin
      check_value(2, "o_de line run", de_run, 640);
      de_lines++;
    end
    check_value(1, "o_hs pulses", hs_pulses, 525);
    check_value(1, "o_vs pulses", vs_pulses, 1);
    check_value(2, "o_de lines", de_lines, 480);
    check_value(2, "o_de total", de_total, 307200);
    check_value(3, "pixel count", n, vga_pkg::VRAM_WORDS);
  endtask

  // one cpu access from the data file
  task automatic do_cpu_op(input int idx);
    logic [19:0]     op;
    logic [19:0]     a;
    logic [19:0]     wd;
    logic [19:0]     xd;
    logic [19:0]     halt;
    vga_pkg::vaddr_t va;
    int              test;
    bit              in_win;
    bit              is_wr;
    bit              got_done;
    op     = tdata[idx*OP_COLS];
    a      = tdata[idx*OP_COLS+1];
    wd     = tdata[idx*OP_COLS+2];
    xd     = tdata[idx*OP_COLS+3];
    halt   = tdata[idx*OP_COLS+4];
    in_win = (a >= vga_pkg::VRAM_BASE) && (a < vga_pkg::VRAM_BASE + vga_pkg::VRAM_WORDS);
    is_wr  = (op == 20'h1);
    va     = vga_pkg::vaddr_t'(a - vga_pkg::VRAM_BASE);
    // out of window, halted, or plain access
    test   = !in_win ? 5 : ((halt != 0) ? 6 : 4);
    @(posedge clk_int);
    #2;
    addr    = a;
    wdata   = wd[15:0];
    write_q = is_wr;
    read_q  = !is_wr;
    rw_halt = (halt != 0);
    prev_de = de;
    // no completion while halted
    for (int k = 0; k < halt; k++) begin
      @(negedge clk_int);
      check_true(6, !(read_dn || write_dn), "done pulse while i_rw_halt was held");
      prev_de = de;
    end
    if (halt != 0) begin
      @(posedge clk_int);
      #2;
      rw_halt = 1'b0;
    end
    got_done = 1'b0;
    while (!got_done) begin
      @(negedge clk_int);
      if (read_dn || write_dn) begin
        got_done = 1'b1;
      end else begin
        prev_de = de;
      end
    end
    if (is_wr) begin
      check_value(test, "o_write_dn", write_dn, 1);
    end else begin
      check_value(test, "o_read_dn", read_dn, 1);
    end
    check_value(test, "o_addr", rd_addr, a);
    if (in_win) begin
      // access fitted into blanking
      check_true(test, !de && !prev_de, "done pulse arrived around active display");
      if (is_wr) begin
        exp_mem[va] = wd[15:0];
        check_value(test, "sram word", sram[va], wd[15:0]);
      end else begin
        check_value(test, "o_data", rd_data, xd);
      end
    end else begin
      check_value(5, "o_data", rd_data, 0);
      compare_memory();
    end
    @(posedge clk_int);
    #2;
    read_q  = 1'b0;
    write_q = 1'b0;
    rw_halt = 1'b0;
    // idle cycle re-arms the port
    @(posedge clk_int);
  endtask

  initial begin
    logic [31:0] seed;
    clk_int = 1'b0;
    rst     = 1'b1;
    addr    = '0;
    wdata   = '0;
    read_q  = 1'b0;
    write_q = 1'b0;
    rw_halt = 1'b0;
    errors  = 0;
    checks  = 0;
    cyc     = 0;
    prev_de = 1'b0;
    timeout_limit = 2 * FRAME_CYCLES + 2000 * MAX_OPS;
    for (int t = 1; t <= 6; t++) begin
      test_err[t] = 0;
      test_chk[t] = 0;
    end
    // preload, address xor a running xorshift value
    seed = 32'd72;
    for (int j = 0; j < SRAM_WORDS; j++) begin
      seed       = xorshift32(seed);
      sram[j]    = 16'(j) ^ seed[15:0];
      exp_mem[j] = 16'(j) ^ seed[15:0];
    end
    // unused entries read as the end marker
    for (int j = 0; j < MAX_OPS * OP_COLS; j++) begin
      tdata[j] = '0;
    end
    $readmemh("testbench/vga_vram_testdata.txt", tdata);
    n_ops = 0;
    while ((n_ops < MAX_OPS) && (tdata[n_ops*OP_COLS] != 20'h0)) begin
      n_ops++;
    end
    timeout_limit = 2 * FRAME_CYCLES + 2000 * n_ops;
    repeat (2) @(posedge clk_int);
    #2;
    rst = 1'b0;
    // first counting edge, frame starts at dot 0 row 0
    @(posedge clk_int);
    run_frame_checks();
    print_test(1, "sync timing");
    print_test(2, "display enable");
    print_test(3, "pixel data");
    // first access lands in active display and must wait for blanking
    while (!de) begin
      @(negedge clk_int);
    end
    for (int i = 0; i < n_ops; i++) begin
      do_cpu_op(i);
    end
    print_test(4, "cpu write then read");
    print_test(5, "out of window");
    print_test(6, "halt back-pressure");
    $display("6 tests, %0d cpu operations, %0d checks, %0d errors", n_ops, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- vga_vram_top.f
design/vga_pkg.sv
design/vga_timing.sv
design/scan_addr.sv
design/cpu_mem_port.sv
design/vram_ctrl.sv
design/vga_vram_top.sv
testbench/vga_vram_chk.sv
testbench/vga_vram_tb.sv

//--- testbench/vga_vram_testdata.txt
// op addr wdata expect halt, all hex, op 1 write, 2 read, 0 ends the list
// window 80000..cafff, halt is the number of cycles i_rw_halt stays high
1 80000 1234 0000 0
1 80005 beef 0000 0
1 cafff 5a5a 0000 0
2 80000 0000 1234 0
2 80005 0000 beef 0
2 cafff 0000 5a5a 0
1 cb000 dead 0000 0
2 7ffff 0000 0000 0
1 81234 0f0f 0000 40
2 81234 0000 0f0f 25
2 80005 0000 beef 0
0 00000 0000 0000 0
